/* bench/snd_ref.svh */
`ifndef SND_REF_SVH
`define SND_REF_SVH

// reference model of the output stage, plain integer math
// included inside snd_out_tb after the package imports

function automatic int clamp_int(input int v, input int lo, input int hi);
	if (v > hi)
		return hi;
	else if (v < lo)
		return lo;
	else
		return v;
endfunction

// panned slot total limited to the 12-bit fm range
function automatic int frame_sum_ref(input int raw);
	return clamp_int(raw, FM_MIN, FM_MAX);
endfunction

// doubled fm side plus eight times the psg level when enabled
function automatic int mix_ref(input int fm, input int lvl, input bit en);
	return 2 * fm + (en ? 8 * lvl : 0);
endfunction

// volume multiplier then 16-bit limits
function automatic int gain_ref(input int pre, input vol_t vol);
	return clamp_int(pre * vol_gain(vol), POST_MIN, POST_MAX);
endfunction

// whole chain for one side of one frame
function automatic int side_ref(input int raw, input int lvl, input bit en, input vol_t vol);
	int fm;
	int pre;
	fm = frame_sum_ref(raw);
	pre = mix_ref(fm, lvl, en);
	return gain_ref(pre, vol);
endfunction

`endif

/* bench/snd_out_tb.sv */
`timescale 1ns/1ps

module snd_out_tb import snd_fmt_pkg::*; import snd_ctl_pkg::*; ();

	// about 520 frames of up to 8 slots plus gaps and idle cycles
	localparam int MAX_CYCLES = 20000;

	logic clk;
	logic rst;
	logic slot_valid;
	logic slot_last;
	logic pan_l;
	logic pan_r;
	logic signed [FM_W-1:0] slot_val;
	logic [PSG_W-1:0] psg;
	logic enable_psg;
	vol_t volume;
	logic signed [POST_W-1:0] post_left;
	logic signed [POST_W-1:0] post_right;
	logic out_valid;

	integer seed = 32'h599fc02c;
	int exp_l_q[$];	// expected outputs with the oldest first
	int exp_r_q[$];
	int due_q[$];	// cycle in which each out_valid must show
	int err_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int frame_len;	// current frame in the buffers below
	int slot_buf[8];
	bit pl_buf[8];
	bit pr_buf[8];
	vol_t sat_vols[3] = '{vol_x1, vol_x16, vol_x24};

	`include "snd_ref.svh"

	snd_out #(
		.ACC_W (16)
	) u_dut (
		.clk        (clk),
		.rst        (rst),
		.slot_valid (slot_valid),
		.slot_last  (slot_last),
		.pan_l      (pan_l),
		.pan_r      (pan_r),
		.slot_val   (slot_val),
		.psg        (psg),
		.enable_psg (enable_psg),
		.volume     (volume),
		.post_left  (post_left),
		.post_right (post_right),
		.out_valid  (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns
	end

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed);
		r = r & 32'h7fff_ffff;	// drop sign before modulo
		return lo + (r % (hi - lo + 1));
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;	// drive just after the edge
	endtask

	task automatic idle_inputs();
		slot_valid = 1'b0;
		slot_last = 1'b0;
		pan_l = 1'b0;
		pan_r = 1'b0;
		slot_val = '0;
	endtask

	task automatic fill_random(input int n, input int lo, input int hi);
		frame_len = n;
		for (int i = 0; i < n; i++) begin
			slot_buf[i] = rand_range(lo, hi);
			pl_buf[i] = rand_range(0, 1) != 0;
			pr_buf[i] = rand_range(0, 1) != 0;
		end
	endtask

	// levels change on the first slot and so hold through the previous frame's sample cycle
	task automatic send_frame(input int lvl, input bit en, input vol_t vol, input bit gaps);
		int raw_l;
		int raw_r;
		raw_l = 0;
		raw_r = 0;
		for (int i = 0; i < frame_len; i++) begin
			next_cycle();
			if (i == 0) begin
				psg = PSG_W'(lvl);
				enable_psg = en;
				volume = vol;
			end
			if (gaps && i > 0 && rand_range(0, 3) == 0) begin
				idle_inputs();
				slot_val = FM_W'(rand_range(-2048, 2047));	// junk that the DUT must ignore
				pan_l = 1'b1;
				pan_r = 1'b1;
				next_cycle();
			end
			slot_valid = 1'b1;
			slot_last = (i == frame_len - 1);
			slot_val = FM_W'(slot_buf[i]);
			pan_l = pl_buf[i];
			pan_r = pr_buf[i];
			if (pl_buf[i])
				raw_l += slot_buf[i];
			if (pr_buf[i])
				raw_r += slot_buf[i];
		end
		exp_l_q.push_back(side_ref(raw_l, lvl, en, vol));
		exp_r_q.push_back(side_ref(raw_r, lvl, en, vol));
		due_q.push_back(cycle_count + 2);	// two cycles from slot_last
		next_cycle();
		idle_inputs();
	endtask

	// one-slot frames on every cycle with levels fixed for the burst
	task automatic burst_frames(input int n, input int lvl, input bit en, input vol_t vol);
		int v;
		bit l;
		bit r;
		for (int i = 0; i < n; i++) begin
			next_cycle();
			psg = PSG_W'(lvl);
			enable_psg = en;
			volume = vol;
			v = rand_range(-2048, 2047);
			l = rand_range(0, 1) != 0;
			r = rand_range(0, 1) != 0;
			slot_valid = 1'b1;
			slot_last = 1'b1;
			slot_val = FM_W'(v);
			pan_l = l;
			pan_r = r;
			exp_l_q.push_back(side_ref(l ? v : 0, lvl, en, vol));
			exp_r_q.push_back(side_ref(r ? v : 0, lvl, en, vol));
			due_q.push_back(cycle_count + 2);
		end
		next_cycle();
		idle_inputs();
	endtask

	task automatic end_test(input string name, input int err_before);
		int errs;
		while (exp_l_q.size() != 0)
			next_cycle();	// every sent frame must come out
		repeat (4) next_cycle();
		errs = err_count - err_before;
		if (errs == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errs);
		end
	endtask

	// each out_valid against the oldest expected frame
	always @(negedge clk) begin : compare_outputs
		int want_l;
		int want_r;
		int due;
		if (!rst && out_valid) begin
			assert (exp_l_q.size() != 0) else begin
				$display("out_valid arrived with no frame waiting for it");
				err_count++;
			end
			if (exp_l_q.size() != 0) begin
				want_l = exp_l_q.pop_front();
				want_r = exp_r_q.pop_front();
				due = due_q.pop_front();
				assert (cycle_count == due) else begin
					$display("out_valid came in cycle %0d but the frame was due in cycle %0d",
						cycle_count, due);
					err_count++;
				end
				assert (post_left === POST_W'(want_l)) else begin
					$display("mismatch post_left: got %h expected %h", post_left,
						POST_W'(want_l));
					err_count++;
				end
				assert (post_right === POST_W'(want_r)) else begin
					$display("mismatch post_right: got %h expected %h", post_right,
						POST_W'(want_r));
					err_count++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		int mark;
		rst = 1'b1;
		idle_inputs();
		psg = '0;
		enable_psg = 1'b0;
		volume = vol_x1;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;

		// quiet outputs after reset
		mark = err_count;
		repeat (10) begin
			@(negedge clk);
			assert (out_valid === 1'b0) else begin
				$display("out_valid high after reset with no slot sent");
				err_count++;
			end
			assert (post_left === 16'h0000 && post_right === 16'h0000) else begin
				$display("mismatch post_left/post_right: got %h/%h expected %h", post_left,
					post_right, 16'h0000);
				err_count++;
			end
		end
		end_test("reset", mark);

		mark = err_count;
		for (int v = 0; v < 8; v++) begin
			repeat (40) begin
				fill_random(rand_range(1, 8), -300, 300);
				send_frame(0, 1'b0, vol_t'(3'(v)), 1'b1);
				if (rand_range(0, 2) == 0)
					next_cycle();	// uneven spacing between frames
			end
		end
		end_test("random frames per volume", mark);

		mark = err_count;
		repeat (5) begin
			fill_random(rand_range(1, 8), -250, 250);
			for (int p = 0; p < 4; p++) begin
				for (int i = 0; i < frame_len; i++) begin
					pl_buf[i] = p[0];	// 1 left, 2 right, 3 both, 0 neither
					pr_buf[i] = p[1];
				end
				send_frame(0, 1'b0, vol_t'(3'(rand_range(0, 7))), 1'b0);
			end
		end
		end_test("pan routing", mark);

		mark = err_count;
		repeat (20) begin
			int lvl;
			lvl = rand_range(0, 63);
			for (int e = 0; e < 2; e++) begin
				fill_random(rand_range(1, 8), 0, 0);	// fm silent
				send_frame(lvl, e != 0, vol_t'(3'(rand_range(0, 7))), 1'b0);
				fill_random(rand_range(1, 8), -400, 400);
				send_frame(lvl, e != 0, vol_t'(3'(rand_range(0, 7))), 1'b1);
			end
		end
		end_test("psg mix", mark);

		mark = err_count;
		for (int k = 0; k < 3; k++) begin
			for (int s = 0; s < 2; s++) begin
				for (int e = 0; e < 2; e++) begin
					frame_len = 8;
					for (int i = 0; i < 8; i++) begin
						slot_buf[i] = (s != 0) ? FM_MIN : FM_MAX;	// sum runs past the limit
						pl_buf[i] = 1'b1;
						pr_buf[i] = 1'b1;
					end
					send_frame(63, e != 0, sat_vols[k], 1'b0);
				end
			end
		end
		repeat (20) begin
			fill_random(rand_range(1, 8), -2048, 2047);
			send_frame(rand_range(0, 63), rand_range(0, 1) != 0,
				(rand_range(0, 1) != 0) ? vol_x24 : vol_x16, 1'b0);
		end
		end_test("saturation", mark);

		mark = err_count;
		burst_frames(32, rand_range(0, 63), 1'b1, vol_x6);
		repeat (3) next_cycle();
		burst_frames(32, 0, 1'b0, vol_x2);
		end_test("back to back frames", mark);

		$display("tests passed %0d, failed %0d, check errors %0d", tests_passed, tests_failed,
			err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* logic/amp_gain.sv */
`timescale 1ns/1ps

// one side of the output amplifier
// multiples by shift and add, then 16-bit saturation
module amp_gain import snd_fmt_pkg::*; import snd_ctl_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     sample,	// load strobe
	input  vol_t                     volume,
	input  logic signed [PRE_W-1:0]  pre,
	output logic signed [POST_W-1:0] post
);

	localparam int MUL_W = PRE_W + GAIN_HEAD;	// room for pre * 24

	logic signed [MUL_W-1:0] x1;
	logic signed [MUL_W-1:0] x2;
	logic signed [MUL_W-1:0] x4;
	logic signed [MUL_W-1:0] x6;
	logic signed [MUL_W-1:0] x8;
	logic signed [MUL_W-1:0] x12;
	logic signed [MUL_W-1:0] x16;
	logic signed [MUL_W-1:0] x24;
	logic signed [MUL_W-1:0] mult;	// selected multiple
	logic [MUL_W-POST_W:0]   mult_hi;	// bits from 15 up
	logic signed [POST_W-1:0] sat;	// saturated result

	// shifts on the sign extended input
	assign x1 = MUL_W'(pre);
	assign x2 = x1 <<< 1;
	assign x4 = x1 <<< 2;
	assign x8 = x1 <<< 3;
	assign x16 = x1 <<< 4;

	// the odd steps come from one add each
	assign x6 = x4 + x2;
	assign x12 = x8 + x4;
	assign x24 = x16 + x8;

	always_comb begin
		case (volume)
			vol_x1:  mult = x1;
			vol_x2:  mult = x2;
			vol_x4:  mult = x4;
			vol_x6:  mult = x6;
			vol_x8:  mult = x8;
			vol_x12: mult = x12;
			vol_x16: mult = x16;
			vol_x24: mult = x24;
			default: mult = x1;
		endcase
	end

	assign mult_hi = mult[MUL_W-1:POST_W-1];

	// fits when all upper bits copy the sign
	always_comb begin
		if (&mult_hi || ~|mult_hi)
			sat = mult[POST_W-1:0];
		else if (mult[MUL_W-1])
			sat = POST_W'(POST_MIN);	// negative overflow
		else
			sat = POST_W'(POST_MAX);	// positive overflow
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			post <= '0;
		end else if (sample) begin
			post <= sat;	// hold between samples
		end
	end

	// volume level comes from outside, must be settled when taken
	a_volume_known: assert property (
		@(posedge clk) disable iff (rst)
		sample |-> !$isunknown(volume)
	) else $error("volume unknown while sample is high");

endmodule

/* logic/amp_stereo.sv */
`timescale 1ns/1ps

// mixes the psg level into both fm sides with one gain stage per side
module amp_stereo import snd_fmt_pkg::*; import snd_ctl_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     sample,
	input  logic [PSG_W-1:0]         psg,	// unsigned level
	input  logic                     enable_psg,
	input  vol_t                     volume,
	input  logic signed [FM_W-1:0]   fm_left,
	input  logic signed [FM_W-1:0]   fm_right,
	output logic signed [POST_W-1:0] post_left,
	output logic signed [POST_W-1:0] post_right,
	output logic                     out_valid
);

	logic signed [PRE_W-1:0] psg_sum;	// 8 * psg or zero
	logic signed [PRE_W-1:0] pre_left;
	logic signed [PRE_W-1:0] pre_right;

	// psg is never negative so zero fill above the level
	assign psg_sum = enable_psg ? {{(PRE_W-PSG_W-3){1'b0}}, psg, 3'b000} : '0;

	// fm doubled then psg on top
	assign pre_left = (PRE_W'(fm_left) <<< 1) + psg_sum;
	assign pre_right = (PRE_W'(fm_right) <<< 1) + psg_sum;

	amp_gain amp_left (
		.clk    (clk),
		.rst    (rst),
		.sample (sample),
		.volume (volume),
		.pre    (pre_left),
		.post   (post_left)
	);

	amp_gain amp_right (
		.clk    (clk),
		.rst    (rst),
		.sample (sample),
		.volume (volume),
		.pre    (pre_right),
		.post   (post_right)
	);

	// flag lines up with the gain registers
	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= sample;
	end

	// psg levels come from outside and must be settled when taken
	a_psg_known: assert property (
		@(posedge clk) disable iff (rst)
		sample |-> !$isunknown({psg, enable_psg})
	) else $error("psg level unknown while sample is high");

endmodule

/* logic/fm_chan_acc.sv */
`timescale 1ns/1ps

// sums the panned fm slots of one frame into a left and a right value
module fm_chan_acc import snd_fmt_pkg::*; #(
	parameter int ACC_W = 16	// running sum width, large enough for the longest frame
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    slot_valid,	// slot_val is live
	input  logic                    slot_last,	// final slot of the frame
	input  logic                    pan_l,	// slot goes to the left sum
	input  logic                    pan_r,	// slot goes to the right sum
	input  logic signed [FM_W-1:0]  slot_val,
	output logic signed [FM_W-1:0]  fm_left,
	output logic signed [FM_W-1:0]  fm_right,
	output logic                    sample	// one pulse per finished frame
);

	logic signed [ACC_W-1:0] sum_l;	// running sums
	logic signed [ACC_W-1:0] sum_r;
	logic signed [ACC_W-1:0] slot_ext;	// slot sign extended
	logic signed [ACC_W-1:0] add_l;	// what this cycle adds
	logic signed [ACC_W-1:0] add_r;
	logic signed [ACC_W-1:0] next_l;	// sums including this slot
	logic signed [ACC_W-1:0] next_r;
	logic                    frame_end;

	// limit a running sum to the 12-bit fm range
	function automatic logic signed [FM_W-1:0] clamp_fm(
		input logic signed [ACC_W-1:0] v
	);
		if (v > FM_MAX)
			return FM_W'(FM_MAX);
		else if (v < FM_MIN)
			return FM_W'(FM_MIN);
		else
			return v[FM_W-1:0];	// in range so the low bits are exact
	endfunction

	assign slot_ext = ACC_W'(slot_val);
	assign frame_end = slot_valid && slot_last;

	// a slot may join one side, both or neither
	assign add_l = (slot_valid && pan_l) ? slot_ext : '0;
	assign add_r = (slot_valid && pan_r) ? slot_ext : '0;
	assign next_l = sum_l + add_l;
	assign next_r = sum_r + add_r;

	always_ff @(posedge clk) begin
		if (rst) begin
			sum_l <= '0;
			sum_r <= '0;
			fm_left <= '0;
			fm_right <= '0;
			sample <= 1'b0;
		end else begin
			sample <= frame_end;	// result lands one cycle after slot_last
			if (frame_end) begin
				fm_left <= clamp_fm(next_l);	// last slot is part of the sum
				fm_right <= clamp_fm(next_r);
				sum_l <= '0;	// next frame may start right away
				sum_r <= '0;
			end else begin
				sum_l <= next_l;	// adds zero when no slot
				sum_r <= next_r;
			end
		end
	end

	// a frame can only end on a real slot
	a_last_needs_valid: assert property (
		@(posedge clk) disable iff (rst)
		slot_last |-> slot_valid
	) else $error("slot_last without slot_valid");

	// slot fields from the fm core must be settled on a live slot
	a_slot_known: assert property (
		@(posedge clk) disable iff (rst)
		slot_valid |-> !$isunknown({slot_last, pan_l, pan_r, slot_val})
	) else $error("slot fields unknown while slot_valid is high");

endmodule

/* logic/snd_ctl_pkg.sv */
package snd_ctl_pkg;

	// volume code, each one names its multiplier
	typedef enum logic [2:0] {
		vol_x1  = 3'd0,
		vol_x2  = 3'd1,
		vol_x4  = 3'd2,
		vol_x6  = 3'd3,	// x4 + x2
		vol_x8  = 3'd4,
		vol_x12 = 3'd5,	// x8 + x4
		vol_x16 = 3'd6,
		vol_x24 = 3'd7	// x16 + x8
	} vol_t;

	// integer multiplier of a code
	function automatic int vol_gain(input vol_t code);
		case (code)
			vol_x1:  return 1;
			vol_x2:  return 2;
			vol_x4:  return 4;
			vol_x6:  return 6;
			vol_x8:  return 8;
			vol_x12: return 12;
			vol_x16: return 16;
			default: return 24;	// vol_x24
		endcase
	endfunction

endpackage

/* logic/snd_fmt_pkg.sv */
package snd_fmt_pkg;

	// fm core side
	localparam int FM_W = 12;	// one slot value, also each clamped frame sum
	localparam int FM_MAX = 2047;	// top of the 12-bit fm range
	localparam int FM_MIN = -2048;	// bottom of the 12-bit fm range

	// square wave level, unsigned
	localparam int PSG_W = 6;

	// mixed value ahead of the gain stage
	// holds 2*fm plus 8*psg with room to spare
	localparam int PRE_W = 14;

	// final output sample
	localparam int POST_W = 16;
	localparam int POST_MAX = 32767;	// 16'h7fff
	localparam int POST_MIN = -32768;	// 16'h8000

	// worst product is pre times 24
	// so five extra bits keep every multiple exact
	localparam int GAIN_HEAD = 5;

endpackage

/* logic/snd_out.sv */
`timescale 1ns/1ps

// fm output stage, frame sums then stereo amp
// slot_last to out_valid is two cycles
module snd_out import snd_fmt_pkg::*; import snd_ctl_pkg::*; #(
	parameter int ACC_W = 16	// passed to the accumulator
) (
	input  logic                     clk,
	input  logic                     rst,
	// slots from the fm core
	input  logic                     slot_valid,
	input  logic                     slot_last,
	input  logic                     pan_l,
	input  logic                     pan_r,
	input  logic signed [FM_W-1:0]   slot_val,
	// levels, taken on the internal sample strobe
	input  logic [PSG_W-1:0]         psg,
	input  logic                     enable_psg,
	input  vol_t                     volume,
	// amplified stereo out
	output logic signed [POST_W-1:0] post_left,
	output logic signed [POST_W-1:0] post_right,
	output logic                     out_valid
);

	logic signed [FM_W-1:0] fm_left;	// clamped frame sums
	logic signed [FM_W-1:0] fm_right;
	logic                   sample;	// new frame sums

	fm_chan_acc #(
		.ACC_W (ACC_W)
	) u_acc (
		.clk        (clk),
		.rst        (rst),
		.slot_valid (slot_valid),
		.slot_last  (slot_last),
		.pan_l      (pan_l),
		.pan_r      (pan_r),
		.slot_val   (slot_val),
		.fm_left    (fm_left),
		.fm_right   (fm_right),
		.sample     (sample)
	);

	amp_stereo u_amp (
		.clk        (clk),
		.rst        (rst),
		.sample     (sample),
		.psg        (psg),
		.enable_psg (enable_psg),
		.volume     (volume),
		.fm_left    (fm_left),
		.fm_right   (fm_right),
		.post_left  (post_left),
		.post_right (post_right),
		.out_valid  (out_valid)
	);

endmodule

/* run.sh */
#!/bin/sh
# build and run the snd_out testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module snd_out_tb \
	-f vlog.f -o snd_out_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/snd_out_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "simulator exited with an error" sim.log && exit 1
exit 0

/* vlog.f */
+incdir+bench
logic/snd_fmt_pkg.sv
logic/snd_ctl_pkg.sv
logic/fm_chan_acc.sv
logic/amp_gain.sv
logic/amp_stereo.sv
logic/snd_out.sv
bench/snd_out_tb.sv
